// ==== hw/core_macros.svh ====
// core configuration constants for widths, the CSR map and UART timing
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path width
`define XLEN 32
// instruction memory holds 2**IMEM_AW words
`define IMEM_AW 6

// board I/O
`define LED_W 4
`define BTN_W 4

// custom CSR map
`define LED_CSR 12'h7C0
`define BTN_CSR 12'h7C1
// write sends low byte, read gives busy in bit 0
`define UART_CSR 12'h7C2

// clocks per serial bit
`define UART_BIT_CLKS 16

`endif

// ==== hw/core_pkg.sv ====
// core package with instruction views, the control word and shared enums
`include "core_macros.svh"

package core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  // byte address into instruction memory
  typedef logic [`IMEM_AW+1:0] addr_t;
  typedef logic [4:0] reg_idx_t;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_system = 7'b1110011
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // imm12 is also the CSR address for system instructions
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_pc_plus_4,
    wb_csr
  } wb_sel_e;

  typedef struct packed {
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    word_t       imm;
    alu_op_e     alu_op;
    logic        b_is_imm;
    wb_sel_e     wb_sel;
    logic        rf_we;
    logic        branch;
    logic        branch_ne;
    logic        jump;
    logic        csr_en;
    logic        csr_set;
    logic [11:0] csr_addr;
  } ctrl_t;

  typedef struct packed {
    logic               en;
    logic [`IMEM_AW-1:0] addr;
    word_t              data;
  } imem_load_t;

endpackage

// ==== hw/instr_decoder.sv ====
// instruction decoder turning one RV32I word into the control word
`timescale 1ns/10ps

module instr_decoder (
  input  core_pkg::instr_u instr,
  output core_pkg::ctrl_t  ctrl
);
  import core_pkg::*;

  word_t   raw;
  word_t   imm_i;
  word_t   imm_u;
  word_t   imm_b;
  word_t   imm_j;
  alu_op_e r_op;
  alu_op_e i_op;
  logic    r_ok;
  logic    i_ok;

  assign raw   = instr;
  assign imm_i = {{20{raw[31]}}, instr.i_fmt.imm12};
  assign imm_u = {raw[31:12], 12'b0};
  assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_j = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};

  // register-register ops, only the base encodings
  always_comb begin
    r_ok = 1'b1;
    case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
      {7'b0000000, 3'b000}: r_op = alu_add;
      {7'b0100000, 3'b000}: r_op = alu_sub;
      {7'b0000000, 3'b111}: r_op = alu_and;
      {7'b0000000, 3'b110}: r_op = alu_or;
      {7'b0000000, 3'b100}: r_op = alu_xor;
      {7'b0000000, 3'b010}: r_op = alu_slt;
      default: begin
        r_op = alu_add;
        r_ok = 1'b0;
      end
    endcase
  end

  // immediate ops
  always_comb begin
    i_ok = 1'b1;
    case (instr.i_fmt.funct3)
      3'b000:  i_op = alu_add;
      3'b111:  i_op = alu_and;
      3'b110:  i_op = alu_or;
      3'b100:  i_op = alu_xor;
      default: begin
        i_op = alu_add;
        i_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    // anything not matched below stays a no-op
    ctrl = '0;
    case (instr.r_fmt.opcode)
      op_lui: begin
        ctrl.rd       = instr.i_fmt.rd;
        ctrl.imm      = imm_u;
        ctrl.alu_op   = alu_pass_b;
        ctrl.b_is_imm = 1'b1;
        ctrl.rf_we    = 1'b1;
      end
      op_imm: if (i_ok) begin
        ctrl.rs1      = instr.i_fmt.rs1;
        ctrl.rd       = instr.i_fmt.rd;
        ctrl.imm      = imm_i;
        ctrl.alu_op   = i_op;
        ctrl.b_is_imm = 1'b1;
        ctrl.rf_we    = 1'b1;
      end
      op_reg: if (r_ok) begin
        ctrl.rs1    = instr.r_fmt.rs1;
        ctrl.rs2    = instr.r_fmt.rs2;
        ctrl.rd     = instr.r_fmt.rd;
        ctrl.alu_op = r_op;
        ctrl.rf_we  = 1'b1;
      end
      // beq and bne only
      op_branch: if (instr.r_fmt.funct3[2:1] == 2'b00) begin
        ctrl.rs1       = instr.r_fmt.rs1;
        ctrl.rs2       = instr.r_fmt.rs2;
        ctrl.imm       = imm_b;
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = instr.r_fmt.funct3[0];
      end
      op_jal: begin
        ctrl.rd     = instr.i_fmt.rd;
        ctrl.imm    = imm_j;
        ctrl.jump   = 1'b1;
        ctrl.wb_sel = wb_pc_plus_4;
        ctrl.rf_we  = 1'b1;
      end
      // csrrw is funct3 001, csrrs is 010
      op_system: if (instr.i_fmt.funct3 inside {3'b001, 3'b010}) begin
        ctrl.rs1      = instr.i_fmt.rs1;
        ctrl.rd       = instr.i_fmt.rd;
        ctrl.csr_en   = 1'b1;
        ctrl.csr_set  = instr.i_fmt.funct3[1];
        ctrl.csr_addr = instr.i_fmt.imm12;
        ctrl.wb_sel   = wb_csr;
        ctrl.rf_we    = 1'b1;
      end
      default: ;
    endcase
  end

  a_branch_jump_excl: assert final (!(ctrl.branch && ctrl.jump))
    else $error("decoder set branch and jump together");

endmodule

// ==== hw/reg_file.sv ====
// 32 x 32 register file, two asynchronous reads and one synchronous write
`timescale 1ns/10ps

module reg_file (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            we,
  input  core_pkg::word_t wdata,
  output core_pkg::word_t rdata1,
  output core_pkg::word_t rdata2
);
  import core_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 is cleared by reset and skipped by every write
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    rs1 == 5'd0 |-> rdata1 == '0)
    else $error("x0 read back nonzero");

endmodule

// ==== hw/alu_branch.sv ====
// ALU with branch compare and next PC selection
`timescale 1ns/10ps

module alu_branch (
  input  core_pkg::ctrl_t ctrl,
  input  core_pkg::addr_t pc,
  input  core_pkg::word_t a,
  input  core_pkg::word_t b,
  output core_pkg::word_t result,
  output core_pkg::word_t pc_plus_4,
  output core_pkg::addr_t next_pc
);
  import core_pkg::*;

  word_t op_b;
  logic  taken;

  assign op_b = ctrl.b_is_imm ? ctrl.imm : b;

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    result = a + op_b;
      alu_sub:    result = a - op_b;
      alu_and:    result = a & op_b;
      alu_or:     result = a | op_b;
      alu_xor:    result = a ^ op_b;
      alu_slt:    result = word_t'($signed(a) < $signed(op_b));
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

  // compare always uses rs2, never the immediate
  assign taken = (ctrl.branch && ((a == b) ^ ctrl.branch_ne)) || ctrl.jump;

  assign pc_plus_4 = word_t'(pc) + word_t'(4);

  // offset wraps inside the small instruction space
  assign next_pc = taken ? pc + addr_t'(ctrl.imm) : addr_t'(pc_plus_4);

endmodule

// ==== hw/instr_mem.sv ====
// instruction RAM with asynchronous read and a word-wide load port
`timescale 1ns/10ps
`include "core_macros.svh"

module instr_mem (
  input  logic                 clk,
  input  core_pkg::imem_load_t load,
  input  core_pkg::addr_t      addr,
  output core_pkg::instr_u     instr
);
  import core_pkg::*;

  word_t mem [2**`IMEM_AW];

  // program load only while the core is halted
  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end
  end

  // byte address to word index
  assign instr = mem[addr[`IMEM_AW+1:2]];

endmodule

// ==== hw/uart_tx.sv ====
// 8N1 serial transmitter with busy flag
`timescale 1ns/10ps
`include "core_macros.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       send,
  input  logic [7:0] data,
  output logic       busy,
  output logic       tx
);
  localparam int CNT_W    = $clog2(`UART_BIT_CLKS);
  localparam int LAST_BIT = 9;

  logic [CNT_W-1:0] clk_cnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]       bit_idx;
  logic [8:0]       shift;
  logic             bit_end;

  assign bit_end = clk_cnt == CNT_W'(`UART_BIT_CLKS - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!busy) begin
      if (send) begin
        // start bit goes out next cycle
        busy    <= 1'b1;
        tx      <= 1'b0;
        clk_cnt <= '0;
        bit_idx <= '0;
      end
    end else if (!bit_end) begin
      clk_cnt <= clk_cnt + 1'b1;
    end else begin
      clk_cnt <= '0;
      if (bit_idx == 4'(LAST_BIT)) begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end else begin
        tx      <= shift[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  // data LSB first, stop bit rides on top
  always_ff @(posedge clk) begin
    if (!busy && send) begin
      shift <= {1'b1, data};
    end else if (busy && bit_end) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

// ==== hw/io_csr.sv ====
// CSR block mapping LEDs, buttons and the UART transmitter
`timescale 1ns/10ps
`include "core_macros.svh"

module io_csr (
  input  logic              clk,
  input  logic              rst_n,
  input  core_pkg::ctrl_t   ctrl,
  input  logic              retire,
  input  core_pkg::word_t   src,
  input  logic [`BTN_W-1:0] btn,
  input  logic              busy,
  output core_pkg::word_t   rdata,
  output logic [`LED_W-1:0] led,
  output logic              send,
  output logic [7:0]        tx_byte
);
  import core_pkg::*;

  logic              csr_write;
  logic [`LED_W-1:0] led_next;

  // csrrs with rs1 = x0 is a pure read
  assign csr_write = ctrl.csr_en && retire && !(ctrl.csr_set && ctrl.rs1 == 5'd0);

  always_comb begin
    case (ctrl.csr_addr)
      `LED_CSR:  rdata = word_t'(led);
      `BTN_CSR:  rdata = word_t'(btn);
      `UART_CSR: rdata = word_t'(busy);
      default:   rdata = '0;
    endcase
  end

  // set ORs the source in, write replaces
  assign led_next = ctrl.csr_set ? (led | src[`LED_W-1:0]) : src[`LED_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led <= '0;
    end else if (csr_write && ctrl.csr_addr == `LED_CSR) begin
      led <= led_next;
    end
  end

  // dropped while the transmitter is busy, software polls
  assign send    = csr_write && ctrl.csr_addr == `UART_CSR && !busy;
  assign tx_byte = src[7:0];

  a_no_send_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(send && busy))
    else $error("uart send raised while busy");

  // transmitter has to take the byte on the same edge
  a_send_taken: assert property (@(posedge clk) disable iff (!rst_n)
    send |=> busy)
    else $error("uart send not accepted");

endmodule

// ==== hw/top_arty.sv ====
// Arty top level for the single-cycle RV32I subset core
`timescale 1ns/10ps
`include "core_macros.svh"

module top_arty (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 run,
  input  core_pkg::imem_load_t load,
  input  logic [`BTN_W-1:0]    btn,
  output logic [`LED_W-1:0]    led,
  output logic                 tx
);
  import core_pkg::*;

  addr_t      pc;
  addr_t      next_pc;
  instr_u     instr;
  ctrl_t      ctrl;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_result;
  word_t      pc_plus_4;
  word_t      csr_rdata;
  word_t      wb_data;
  logic       uart_send;
  logic       uart_busy;
  logic [7:0] uart_byte;

  // one instruction per cycle while running
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= next_pc;
    end
  end

  instr_mem u_imem (
    .clk,
    .load,
    .addr (pc),
    .instr(instr)
  );

  instr_decoder u_decoder (
    .instr,
    .ctrl
  );

  reg_file u_rf (
    .clk,
    .rst_n,
    .rs1   (ctrl.rs1),
    .rs2   (ctrl.rs2),
    .rd    (ctrl.rd),
    .we    (ctrl.rf_we && run),
    .wdata (wb_data),
    .rdata1(rs1_data),
    .rdata2(rs2_data)
  );

  alu_branch u_alu (
    .ctrl,
    .pc,
    .a        (rs1_data),
    .b        (rs2_data),
    .result   (alu_result),
    .pc_plus_4(pc_plus_4),
    .next_pc  (next_pc)
  );

  // rs1 is the CSR write source
  io_csr u_csr (
    .clk,
    .rst_n,
    .ctrl,
    .retire (run),
    .src    (rs1_data),
    .btn,
    .busy   (uart_busy),
    .rdata  (csr_rdata),
    .led,
    .send   (uart_send),
    .tx_byte(uart_byte)
  );

  uart_tx u_uart (
    .clk,
    .rst_n,
    .send(uart_send),
    .data(uart_byte),
    .busy(uart_busy),
    .tx
  );

  // write-back select
  always_comb begin
    case (ctrl.wb_sel)
      wb_pc_plus_4: wb_data = pc_plus_4;
      wb_csr:       wb_data = csr_rdata;
      default:      wb_data = alu_result;
    endcase
  end

endmodule

// ==== test/tb_programs.svh ====
// RV32I instruction encoders and program loading for the core testbench
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// program image, word 0 first
word_t prog [2**`IMEM_AW];
int    prog_len;

function automatic word_t i_type_word(input int imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opcode);
  return {12'(imm), rs1, f3, rd, opcode};
endfunction

function automatic word_t r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t addi(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
  return i_type_word(imm, rs1, 3'b000, rd, 7'b0010011);
endfunction

// op 0..5 is add, sub, and, or, xor, slt
function automatic word_t arith_instr(input int op, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
  case (op)
    0:       return r_type_word(7'b0000000, rs2, rs1, 3'b000, rd);
    1:       return r_type_word(7'b0100000, rs2, rs1, 3'b000, rd);
    2:       return r_type_word(7'b0000000, rs2, rs1, 3'b111, rd);
    3:       return r_type_word(7'b0000000, rs2, rs1, 3'b110, rd);
    4:       return r_type_word(7'b0000000, rs2, rs1, 3'b100, rd);
    default: return r_type_word(7'b0000000, rs2, rs1, 3'b010, rd);
  endcase
endfunction

// byte offset from this instruction
function automatic word_t bne(input logic [4:0] rs1, input logic [4:0] rs2, input int off);
  logic [12:0] o;
  o = 13'(off);
  return {o[12], o[10:5], rs2, rs1, 3'b001, o[4:1], o[11], 7'b1100011};
endfunction

function automatic word_t jal(input logic [4:0] rd, input int off);
  logic [20:0] o;
  o = 21'(off);
  return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
endfunction

function automatic word_t csrrw(input logic [4:0] rd, input logic [11:0] csr,
                                input logic [4:0] rs1);
  return i_type_word(int'(csr), rs1, 3'b001, rd, 7'b1110011);
endfunction

function automatic word_t csrrs(input logic [4:0] rd, input logic [11:0] csr,
                                input logic [4:0] rs1);
  return i_type_word(int'(csr), rs1, 3'b010, rd, 7'b1110011);
endfunction

// every program ends in a jal-to-self spin
function automatic addr_t end_addr();
  return addr_t'(4 * (prog_len - 1));
endfunction

task automatic clear_program();
  prog_len = 0;
endtask

task automatic emit(input word_t w);
  prog[prog_len] = w;
  prog_len++;
endtask

// one word per cycle through the load port, core halted
task automatic load_program();
  for (int i = 0; i < prog_len; i++) begin
    @(posedge clk);
    load <= '{en: 1'b1, addr: `IMEM_AW'(i), data: prog[i]};
  end
  @(posedge clk);
  load <= '0;
endtask

task automatic start_program();
  pulse_reset();
  load_program();
  @(posedge clk);
  run <= 1'b1;
endtask

`endif

// ==== test/tb_top_arty.sv ====
// testbench for the Arty RV32I subset core, directed programs checked on LEDs and UART
`timescale 1ns/10ps
`include "core_macros.svh"

module tb_top_arty;
  import core_pkg::*;

  logic              clk;
  logic              rst_n;
  logic              run;
  imem_load_t        load;
  logic [`BTN_W-1:0] btn;
  logic [`LED_W-1:0] led;
  logic              tx;

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lcg_state;

  `include "tb_programs.svh"

  top_arty u_dut (
    .clk,
    .rst_n,
    .run,
    .load,
    .btn,
    .led,
    .tx
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // upper bits only, the low LCG bits repeat quickly
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {8'b0, lcg_state[31:8]};
  endfunction

  task automatic check_led(input string name, input logic [`LED_W-1:0] got,
                           input logic [`LED_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    run   <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // done once the PC sits on the final spin
  task automatic wait_pc(input addr_t target, input int limit);
    int n = 0;
    while (u_dut.pc !== target && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (u_dut.pc !== target) begin
      report_timeout("the program to reach its end loop");
    end
  endtask

  // sample each bit in its middle, counted from the falling start edge
  task automatic receive_byte(input string name, input logic [7:0] exp);
    int          n = 0;
    logic [7:0] data;
    while (tx !== 1'b0 && n < 400) begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0) begin
      report_timeout("a UART start bit");
    end else begin
      repeat (`UART_BIT_CLKS / 2) @(negedge clk);
      check_bit("tx start bit", tx, 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (`UART_BIT_CLKS) @(negedge clk);
        data[i] = tx;
      end
      check_byte(name, data, exp);
      repeat (`UART_BIT_CLKS) @(negedge clk);
      check_bit("tx stop bit", tx, 1'b1);
    end
  endtask

  task automatic test_reset_state();
    int e = errors;
    pulse_reset();
    @(negedge clk);
    check_led("led", led, '0);
    check_bit("tx", tx, 1'b1);
    finish_test("reset", e);
  endtask

  task automatic test_arith();
    int          e = errors;
    logic [11:0] ia;
    logic [11:0] ib;
    word_t       a;
    word_t       b;
    word_t       exp;
    for (int op = 0; op < 6; op++) begin
      ia = 12'(next_rand());
      ib = 12'(next_rand());
      a  = {{20{ia[11]}}, ia};
      b  = {{20{ib[11]}}, ib};
      case (op)
        0:       exp = a + b;
        1:       exp = a - b;
        2:       exp = a & b;
        3:       exp = a | b;
        4:       exp = a ^ b;
        default: exp = word_t'($signed(a) < $signed(b));
      endcase
      clear_program();
      emit(addi(5'd1, 5'd0, int'(ia)));
      emit(addi(5'd2, 5'd0, int'(ib)));
      emit(arith_instr(op, 5'd3, 5'd1, 5'd2));
      emit(csrrw(5'd0, `LED_CSR, 5'd3));
      emit(jal(5'd0, 0));
      start_program();
      wait_pc(end_addr(), 50);
      check_led("led", led, exp[`LED_W-1:0]);
    end
    finish_test("arith", e);
  endtask

  task automatic test_branch_loop();
    int e = errors;
    int n;
    n = 1 + int'(next_rand() % 40);
    clear_program();
    emit(addi(5'd1, 5'd0, n));
    emit(addi(5'd2, 5'd0, 0));
    emit(addi(5'd2, 5'd2, 1));
    emit(addi(5'd1, 5'd1, -1));
    emit(bne(5'd1, 5'd0, -8));
    emit(csrrw(5'd0, `LED_CSR, 5'd2));
    emit(jal(5'd0, 0));
    start_program();
    wait_pc(end_addr(), 4 * n + 20);
    check_led("led", led, `LED_W'(n % 16));
    finish_test("branch loop", e);
  endtask

  task automatic test_csr_set();
    int                e = errors;
    logic [`LED_W-1:0] m1;
    logic [`LED_W-1:0] m2;
    logic [`BTN_W-1:0] bval;
    // each source owns one LED bit of its own
    m1   = (`LED_W'(next_rand()) & `LED_W'(4'b1001)) | `LED_W'(4'b0001);
    m2   = (`LED_W'(next_rand()) & `LED_W'(4'b1010)) | `LED_W'(4'b0010);
    bval = (`BTN_W'(next_rand()) & `BTN_W'(4'b1100)) | `BTN_W'(4'b0100);
    @(posedge clk);
    btn <= bval;
    clear_program();
    emit(addi(5'd1, 5'd0, int'(m1)));
    emit(addi(5'd2, 5'd0, int'(m2)));
    emit(csrrs(5'd0, `LED_CSR, 5'd1));
    emit(csrrs(5'd0, `LED_CSR, 5'd2));
    // read only, rs1 is x0
    emit(csrrs(5'd3, `BTN_CSR, 5'd0));
    emit(csrrs(5'd0, `LED_CSR, 5'd3));
    emit(jal(5'd0, 0));
    start_program();
    wait_pc(end_addr(), 50);
    check_led("led", led, m1 | m2 | `LED_W'(bval));
    finish_test("csr set", e);
  endtask

  task automatic test_uart();
    int         e = errors;
    logic [7:0] b1;
    logic [7:0] b2;
    b1 = 8'(next_rand());
    b2 = 8'(next_rand());
    clear_program();
    emit(addi(5'd1, 5'd0, int'(b1)));
    emit(addi(5'd2, 5'd0, int'(b2)));
    emit(csrrw(5'd0, `UART_CSR, 5'd1));
    // poll busy until the first frame is out
    emit(csrrs(5'd3, `UART_CSR, 5'd0));
    emit(bne(5'd3, 5'd0, -4));
    emit(csrrw(5'd0, `UART_CSR, 5'd2));
    emit(jal(5'd0, 0));
    start_program();
    receive_byte("uart byte 1", b1);
    receive_byte("uart byte 2", b2);
    finish_test("uart", e);
  endtask

  task automatic test_run_hold();
    int                e = errors;
    int                n;
    logic [`LED_W-1:0] held;
    n = 20 + int'(next_rand() % 20);
    clear_program();
    emit(addi(5'd1, 5'd0, n));
    emit(addi(5'd2, 5'd0, 0));
    emit(addi(5'd2, 5'd2, 1));
    emit(csrrw(5'd0, `LED_CSR, 5'd2));
    emit(addi(5'd1, 5'd1, -1));
    emit(bne(5'd1, 5'd0, -12));
    emit(jal(5'd0, 0));
    start_program();
    // halt partway through the loop
    repeat (30) @(posedge clk);
    run <= 1'b0;
    @(negedge clk);
    held = led;
    for (int i = 0; i < 50 && errors == e; i++) begin
      @(negedge clk);
      check_led("led", led, held);
    end
    @(posedge clk);
    run <= 1'b1;
    wait_pc(end_addr(), 4 * n + 40);
    check_led("led", led, `LED_W'(n % 16));
    finish_test("run hold", e);
  endtask

  initial begin
    rst_n        = 1'b0;
    run          = 1'b0;
    load         = '0;
    btn          = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lcg_state    = 32'd27125;
    test_reset_state();
    test_arith();
    test_branch_loop();
    test_csr_set();
    test_uart();
    test_run_hold();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+hw
+incdir+test
hw/core_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu_branch.sv
hw/instr_mem.sv
hw/uart_tx.sv
hw/io_csr.sv
hw/top_arty.sv
test/tb_top_arty.sv

// ==== Bender.yml ====
package:
  name: arty_rv32i_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/instr_decoder.sv
      - hw/reg_file.sv
      - hw/alu_branch.sv
      - hw/instr_mem.sv
      - hw/uart_tx.sv
      - hw/io_csr.sv
      - hw/top_arty.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_top_arty.sv
